// ==== source/tc_cfg_pkg.sv ====
`default_nettype none

package tc_cfg_pkg;

    typedef enum logic [1:0] {
        M32K16N8  = 2'd0,
        M16K16N16 = 2'd1,
        M8K16N32  = 2'd2      // 2'd3 unused
    } shape_t;

    typedef enum logic [1:0] {
        FP32 = 2'd0,
        FP16 = 2'd1,
        INT8 = 2'd2,
        INT4 = 2'd3
    } dtype_t;

    // Compute phases after the load
    typedef enum logic [2:0] {
        PH_IDLE,
        SYSTOLIC,
        ACCUMULATE,
        WAIT_WRITE,
        WRITE_BACK
    } phase_t;

    localparam int TILE_COUNT  = 4;     // Same for every shape
    localparam int K_DEPTH     = 16;
    localparam int WAIT_FACTOR = 1;     // INT4 write wait in units of ARRAY_DIM

    // Fill, stream and drain of the array, for every tile
    function automatic int systolic_cycles(input int array_dim);
        return TILE_COUNT * (K_DEPTH + 2 * array_dim - 2);
    endfunction

endpackage

`default_nettype wire

// ==== source/tc_xfer_pkg.sv ====
`default_nettype none

package tc_xfer_pkg;

    localparam int ADDR_W       = 32;
    localparam int BURST_NUM_W  = 6;    // Beats minus one
    localparam int BURST_SIZE_W = 3;    // Log2 of bytes per beat

    // One-hot matrix select on the request port
    typedef enum logic [2:0] {
        MAT_C = 3'b001,
        MAT_B = 3'b010,
        MAT_A = 3'b100
    } mat_t;

    localparam logic [ADDR_W-1:0] BASE_A = 32'h0010_0000;
    localparam logic [ADDR_W-1:0] BASE_B = 32'h0100_0000;
    localparam logic [ADDR_W-1:0] BASE_C = 32'h0001_0000;

    // Bytes per beat for the narrower element sizes
    localparam logic [BURST_SIZE_W-1:0] SIZE_32B = 3'd5;
    localparam logic [BURST_SIZE_W-1:0] SIZE_16B = 3'd4;
    localparam logic [BURST_SIZE_W-1:0] SIZE_8B  = 3'd3;
    localparam logic [BURST_SIZE_W-1:0] SIZE_4B  = 3'd2;

endpackage

`default_nettype wire

// ==== source/job_decode.sv ====
`default_nettype none
`timescale 1ns/100ps

module job_decode (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic                                   busy,
    input  logic                                   mixed,
    input  tc_cfg_pkg::shape_t                     compute_shape,
    input  tc_cfg_pkg::dtype_t                     data_type,
    output tc_cfg_pkg::dtype_t                     job_dtype,
    output logic [tc_xfer_pkg::BURST_NUM_W-1:0]    c_num,
    output logic [tc_xfer_pkg::BURST_NUM_W-1:0]    a_num,
    output logic [tc_xfer_pkg::BURST_NUM_W-1:0]    b_num,
    output logic [tc_xfer_pkg::BURST_SIZE_W-1:0]   c_size,
    output logic [tc_xfer_pkg::BURST_SIZE_W-1:0]   a_size,
    output logic [tc_xfer_pkg::BURST_SIZE_W-1:0]   b_size
);
    import tc_cfg_pkg::*;
    import tc_xfer_pkg::*;

    shape_t     job_shape;
    logic       job_mixed;
    logic [2:0] a_shift;

    always_ff @(posedge clk) begin
        if (rst) begin
            job_shape <= M32K16N8;
            job_dtype <= FP32;
            job_mixed <= 1'b0;
        end else if (start && !busy) begin
            job_shape <= compute_shape;
            job_dtype <= data_type;
            job_mixed <= mixed;
        end
    end

    // C is always 32 beats, beat width follows the element size
    assign c_num = 6'd31;

    always_comb begin
        case (job_dtype)
            FP32:    c_size = SIZE_32B;
            FP16:    c_size = job_mixed ? SIZE_32B : SIZE_16B;   // Mixed keeps FP32 accumulators
            INT8:    c_size = SIZE_8B;
            default: c_size = SIZE_4B;
        endcase
    end

    // A halves with each narrower shape or type
    assign a_shift = 3'(job_shape) + 3'(job_dtype);
    assign a_num   = {BURST_NUM_W{1'b1}} >> a_shift;
    assign a_size  = SIZE_32B;

    always_comb begin
        b_num  = 6'd15;
        b_size = SIZE_32B;
        case ({job_shape, job_dtype})
            {M32K16N8, FP16}:   b_size = SIZE_16B;
            {M32K16N8, INT8}:   b_size = SIZE_8B;
            {M32K16N8, INT4}:   b_size = SIZE_4B;
            {M16K16N16, FP32}:  b_num  = 6'd31;
            {M16K16N16, INT8}:  b_size = SIZE_16B;
            {M16K16N16, INT4}:  b_size = SIZE_8B;
            {M8K16N32, FP32}:   b_num  = 6'd63;
            {M8K16N32, FP16}:   b_num  = 6'd31;
            {M8K16N32, INT4}:   b_size = SIZE_16B;
            default: ;
        endcase
    end

    a_shape_valid: assert property (@(posedge clk) disable iff (rst)
        job_shape inside {M32K16N8, M16K16N16, M8K16N32})
        else $error("job_decode: unused shape encoding latched");

endmodule

`default_nettype wire

// ==== source/load_sequencer.sv ====
`default_nettype none
`timescale 1ns/100ps

module load_sequencer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic                                   busy,
    input  logic [tc_xfer_pkg::BURST_NUM_W-1:0]    c_num,
    input  logic [tc_xfer_pkg::BURST_NUM_W-1:0]    a_num,
    input  logic [tc_xfer_pkg::BURST_NUM_W-1:0]    b_num,
    input  logic [tc_xfer_pkg::BURST_SIZE_W-1:0]   c_size,
    input  logic [tc_xfer_pkg::BURST_SIZE_W-1:0]   a_size,
    input  logic [tc_xfer_pkg::BURST_SIZE_W-1:0]   b_size,
    input  logic                                   arready,
    input  logic                                   xfer_finish,
    input  logic                                   beat_valid,
    output logic                                   req_valid,
    output tc_xfer_pkg::mat_t                      req_sel,
    output logic [tc_xfer_pkg::ADDR_W-1:0]         req_base,
    output logic [tc_xfer_pkg::BURST_NUM_W-1:0]    req_burst_num,
    output logic [tc_xfer_pkg::BURST_SIZE_W-1:0]   req_burst_size,
    output logic                                   load_done,
    output logic                                   beat_error
);
    import tc_xfer_pkg::*;

    localparam int CNT_W = BURST_NUM_W + 1;

    typedef enum logic [1:0] {
        IDLE,
        READ_C,
        LOAD_A,
        LOAD_B
    } seq_state_t;

    seq_state_t       state;
    logic [CNT_W-1:0] beat_cnt;
    logic [CNT_W-1:0] beat_total;
    logic [CNT_W-1:0] beat_expect;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            req_valid <= 1'b0;
        end else begin
            if (req_valid && arready) begin
                req_valid <= 1'b0;      // Address phase taken
            end
            case (state)
                IDLE: if (start && !busy) begin
                    state     <= READ_C;
                    req_valid <= 1'b1;
                end
                READ_C: if (xfer_finish) begin
                    state     <= LOAD_A;
                    req_valid <= 1'b1;
                end
                LOAD_A: if (xfer_finish) begin
                    state     <= LOAD_B;
                    req_valid <= 1'b1;
                end
                default: if (xfer_finish) begin
                    state <= IDLE;      // Array takes over
                end
            endcase
        end
    end

    // Fields follow the state so they hold while req_valid waits
    always_comb begin
        req_sel        = MAT_C;
        req_base       = BASE_C;
        req_burst_num  = c_num;
        req_burst_size = c_size;
        case (state)
            LOAD_A: begin
                req_sel        = MAT_A;
                req_base       = BASE_A;
                req_burst_num  = a_num;
                req_burst_size = a_size;
            end
            LOAD_B: begin
                req_sel        = MAT_B;
                req_base       = BASE_B;
                req_burst_num  = b_num;
                req_burst_size = b_size;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || xfer_finish) begin
            beat_cnt <= '0;
        end else if (beat_valid) begin
            beat_cnt <= beat_cnt + CNT_W'(1);
        end
    end

    // A beat in the finish cycle still counts
    assign beat_total  = beat_cnt + CNT_W'(beat_valid);
    assign beat_expect = CNT_W'(req_burst_num) + CNT_W'(1);

    assign load_done  = xfer_finish && (state == LOAD_B);
    assign beat_error = xfer_finish && (state != IDLE) && (beat_total != beat_expect);

    a_finish_after_req: assert property (@(posedge clk) disable iff (rst)
        xfer_finish |-> !req_valid)
        else $error("load_sequencer: finish while request pending");

endmodule

`default_nettype wire

// ==== source/compute_timer.sv ====
`default_nettype none
`timescale 1ns/100ps

module compute_timer #(
    parameter int ARRAY_DIM = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_done,
    input  tc_cfg_pkg::dtype_t job_dtype,
    output logic               compute_done
);
    import tc_cfg_pkg::*;

    localparam int SYS_CYCLES  = systolic_cycles(ARRAY_DIM);
    localparam int WAIT_CYCLES = WAIT_FACTOR * ARRAY_DIM;
    localparam int MAX_CYCLES  = (SYS_CYCLES > WAIT_CYCLES) ? SYS_CYCLES : WAIT_CYCLES;
    localparam int CNT_W       = $clog2(MAX_CYCLES);

    phase_t           phase;
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase        <= PH_IDLE;
            cnt          <= '0;
            compute_done <= 1'b0;
        end else begin
            compute_done <= 1'b0;
            case (phase)
                PH_IDLE: if (load_done) begin
                    phase <= SYSTOLIC;
                    cnt   <= CNT_W'(SYS_CYCLES - 1);
                end
                SYSTOLIC: begin
                    cnt <= cnt - CNT_W'(1);
                    if (cnt == '0) begin
                        phase <= (job_dtype == INT4) ? ACCUMULATE : WRITE_BACK;
                    end
                end
                ACCUMULATE: begin       // INT4 partial sums merged
                    phase <= WAIT_WRITE;
                    cnt   <= CNT_W'(WAIT_CYCLES - 1);
                end
                WAIT_WRITE: begin
                    cnt <= cnt - CNT_W'(1);
                    if (cnt == '0) begin
                        phase <= WRITE_BACK;
                    end
                end
                default: begin
                    phase        <= PH_IDLE;
                    compute_done <= 1'b1;
                end
            endcase
        end
    end

    a_load_when_idle: assert property (@(posedge clk) disable iff (rst)
        load_done |-> phase == PH_IDLE)
        else $error("compute_timer: load_done during compute");

endmodule

`default_nettype wire

// ==== source/job_status.sv ====
`default_nettype none
`timescale 1ns/100ps

module job_status #(
    parameter int CYCLE_W = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic               beat_error,
    input  logic               compute_done,
    output logic               busy,
    output logic               done,
    output logic               xfer_error,
    output logic [CYCLE_W-1:0] job_cycles
);

    logic accept;

    assign accept = start && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            xfer_error <= 1'b0;
            job_cycles <= '0;
        end else if (accept) begin
            busy       <= 1'b1;
            done       <= 1'b0;
            xfer_error <= 1'b0;     // Cleared only by a new job
            job_cycles <= '0;
        end else begin
            if (busy) begin
                job_cycles <= job_cycles + CYCLE_W'(1);
            end
            if (beat_error) begin
                xfer_error <= 1'b1;
            end
            if (compute_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/tensor_sched.sv ====
`default_nettype none
`timescale 1ns/100ps

module tensor_sched #(
    parameter int ARRAY_DIM = 8,
    parameter int CYCLE_W   = 16
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic                                   mixed,
    input  tc_cfg_pkg::shape_t                     compute_shape,
    input  tc_cfg_pkg::dtype_t                     data_type,
    input  logic                                   arready,
    input  logic                                   xfer_finish,
    input  logic                                   beat_valid,
    output logic                                   req_valid,
    output tc_xfer_pkg::mat_t                      req_sel,
    output logic [tc_xfer_pkg::ADDR_W-1:0]         req_base,
    output logic [tc_xfer_pkg::BURST_NUM_W-1:0]    req_burst_num,
    output logic [tc_xfer_pkg::BURST_SIZE_W-1:0]   req_burst_size,
    output logic                                   busy,
    output logic                                   done,
    output logic                                   xfer_error,
    output logic [CYCLE_W-1:0]                     job_cycles
);
    import tc_cfg_pkg::*;
    import tc_xfer_pkg::*;

    dtype_t                  job_dtype;
    logic [BURST_NUM_W-1:0]  c_num;
    logic [BURST_NUM_W-1:0]  a_num;
    logic [BURST_NUM_W-1:0]  b_num;
    logic [BURST_SIZE_W-1:0] c_size;
    logic [BURST_SIZE_W-1:0] a_size;
    logic [BURST_SIZE_W-1:0] b_size;
    logic                    load_done;
    logic                    beat_error;
    logic                    compute_done;

    job_decode u_job_decode (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .busy          (busy),
        .mixed         (mixed),
        .compute_shape (compute_shape),
        .data_type     (data_type),
        .job_dtype     (job_dtype),
        .c_num         (c_num),
        .a_num         (a_num),
        .b_num         (b_num),
        .c_size        (c_size),
        .a_size        (a_size),
        .b_size        (b_size)
    );

    load_sequencer u_load_sequencer (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .busy           (busy),
        .c_num          (c_num),
        .a_num          (a_num),
        .b_num          (b_num),
        .c_size         (c_size),
        .a_size         (a_size),
        .b_size         (b_size),
        .arready        (arready),
        .xfer_finish    (xfer_finish),
        .beat_valid     (beat_valid),
        .req_valid      (req_valid),
        .req_sel        (req_sel),
        .req_base       (req_base),
        .req_burst_num  (req_burst_num),
        .req_burst_size (req_burst_size),
        .load_done      (load_done),
        .beat_error     (beat_error)
    );

    compute_timer #(
        .ARRAY_DIM (ARRAY_DIM)
    ) u_compute_timer (
        .clk          (clk),
        .rst          (rst),
        .load_done    (load_done),
        .job_dtype    (job_dtype),
        .compute_done (compute_done)
    );

    job_status #(
        .CYCLE_W (CYCLE_W)
    ) u_job_status (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .beat_error   (beat_error),
        .compute_done (compute_done),
        .busy         (busy),
        .done         (done),
        .xfer_error   (xfer_error),
        .job_cycles   (job_cycles)
    );

endmodule

`default_nettype wire

// ==== tb/tb_tensor_sched.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_tensor_sched;
    import tc_cfg_pkg::*;
    import tc_xfer_pkg::*;

    localparam int ARRAY_DIM   = 8;
    localparam int CYCLE_W     = 16;
    localparam int SYS_CYCLES  = TILE_COUNT * (K_DEPTH + 2 * ARRAY_DIM - 2);
    localparam int LAT_PLAIN   = SYS_CYCLES + 2;            // Write-back, then done
    localparam int LAT_INT4    = SYS_CYCLES + 1 + ARRAY_DIM + 2;
    localparam int MAX_DELAY   = 7;                         // Three LFSR bits
    localparam int NUM_JOBS    = 38;
    localparam int JOB_MAX     = 3 * (MAX_DELAY + 70) + LAT_INT4 + 10;
    localparam int WATCHDOG_NS = (NUM_JOBS * JOB_MAX + 50) * 20;

    // Rows M32K16N8, M16K16N16, M8K16N32; columns FP32, FP16, INT8, INT4
    localparam logic [BURST_NUM_W-1:0] A_NUM [3][4] = '{'{6'd63, 6'd31, 6'd15, 6'd7},
                                                        '{6'd31, 6'd15, 6'd7, 6'd3},
                                                        '{6'd15, 6'd7, 6'd3, 6'd1}};
    localparam logic [BURST_NUM_W-1:0] B_NUM [3][4] = '{'{6'd15, 6'd15, 6'd15, 6'd15},
                                                        '{6'd31, 6'd15, 6'd15, 6'd15},
                                                        '{6'd63, 6'd31, 6'd15, 6'd15}};
    localparam logic [BURST_SIZE_W-1:0] B_SIZE [3][4] = '{'{3'd5, 3'd4, 3'd3, 3'd2},
                                                          '{3'd5, 3'd5, 3'd4, 3'd3},
                                                          '{3'd5, 3'd5, 3'd5, 3'd4}};
    localparam logic [BURST_SIZE_W-1:0] C_SIZE [4] = '{3'd5, 3'd4, 3'd3, 3'd2};

    logic                    clk;
    logic                    rst;
    logic                    start;
    logic                    mixed;
    shape_t                  compute_shape;
    dtype_t                  data_type;
    logic                    arready;
    logic                    xfer_finish;
    logic                    beat_valid;
    logic                    req_valid;
    mat_t                    req_sel;
    logic [ADDR_W-1:0]       req_base;
    logic [BURST_NUM_W-1:0]  req_burst_num;
    logic [BURST_SIZE_W-1:0] req_burst_size;
    logic                    busy;
    logic                    done;
    logic                    xfer_error;
    logic [CYCLE_W-1:0]      job_cycles;

    logic [15:0]             lfsr_state;
    string                   test_name;
    shape_t                  next_shape;
    shape_t                  cur_shape;
    dtype_t                  next_dtype;
    dtype_t                  cur_dtype;
    logic                    next_mixed;
    logic                    cur_mixed;
    logic                    next_short;
    logic                    cur_short;
    logic [1:0]              req_idx;                   // Requests taken in this job
    mat_t                    exp_sel;
    logic [ADDR_W-1:0]       exp_base;
    logic [BURST_NUM_W-1:0]  exp_num;
    logic [BURST_SIZE_W-1:0] exp_size;
    int                      exp_lat;
    int                      cyc = 0;
    int                      acc_cyc;
    int                      since_b;
    int                      jobs = 0;
    int                      tests_run = 0;
    int                      tests_failed = 0;
    int                      err_desc = 0;
    int                      err_hold = 0;
    int                      err_drop = 0;
    int                      err_extra = 0;
    int                      err_count = 0;
    int                      err_lat = 0;
    int                      err_cycles = 0;
    int                      err_flag = 0;
    int                      err_clear = 0;
    int                      err_reset = 0;
    int                      err_timeout = 0;

    tensor_sched #(
        .ARRAY_DIM (ARRAY_DIM),
        .CYCLE_W   (CYCLE_W)
    ) u_tensor_sched (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .mixed          (mixed),
        .compute_shape  (compute_shape),
        .data_type      (data_type),
        .arready        (arready),
        .xfer_finish    (xfer_finish),
        .beat_valid     (beat_valid),
        .req_valid      (req_valid),
        .req_sel        (req_sel),
        .req_base       (req_base),
        .req_burst_num  (req_burst_num),
        .req_burst_size (req_burst_size),
        .busy           (busy),
        .done           (done),
        .xfer_error     (xfer_error),
        .job_cycles     (job_cycles)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // Job seen by the DUT, latched like the DUT on an accepted start
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rst) begin
            cur_shape <= M32K16N8;
            cur_dtype <= FP32;
            cur_mixed <= 1'b0;
            cur_short <= 1'b0;
            req_idx   <= 2'd0;
            acc_cyc   <= 0;
        end else if (start && !busy) begin
            cur_shape <= next_shape;
            cur_dtype <= next_dtype;
            cur_mixed <= next_mixed;
            cur_short <= next_short;
            req_idx   <= 2'd0;
            acc_cyc   <= cyc;
        end else if (req_valid && arready) begin
            req_idx <= req_idx + 2'd1;
        end
        if (rst || (xfer_finish && req_idx == 2'd3)) begin
            since_b <= 0;                                   // Finish of B
        end else begin
            since_b <= since_b + 1;
        end
    end

    always_comb begin
        exp_sel  = MAT_C;
        exp_base = BASE_C;
        exp_num  = 6'd31;
        exp_size = (cur_dtype == FP16 && cur_mixed) ? 3'd5 : C_SIZE[cur_dtype];
        case (req_idx)
            2'd1: begin
                exp_sel  = MAT_A;
                exp_base = BASE_A;
                exp_num  = A_NUM[cur_shape][cur_dtype];
                exp_size = 3'd5;
            end
            2'd2: begin
                exp_sel  = MAT_B;
                exp_base = BASE_B;
                exp_num  = B_NUM[cur_shape][cur_dtype];
                exp_size = B_SIZE[cur_shape][cur_dtype];
            end
            default: ;
        endcase
        exp_lat = (cur_dtype == INT4) ? LAT_INT4 : LAT_PLAIN;
    end

    a_desc: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> {req_sel, req_base, req_burst_num, req_burst_size}
                      == {exp_sel, exp_base, exp_num, exp_size})
        else begin
            err_desc = err_desc + 1;
            $display("FAILED %s: expected %b/%h/%0d/%0d actual %b/%h/%0d/%0d", test_name,
                     $sampled(exp_sel), $sampled(exp_base), $sampled(exp_num),
                     $sampled(exp_size), $sampled(req_sel), $sampled(req_base),
                     $sampled(req_burst_num), $sampled(req_burst_size));
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        req_valid && !arready |=> req_valid
            && $stable({req_sel, req_base, req_burst_num, req_burst_size}))
        else begin
            err_hold = err_hold + 1;
            $display("Request dropped or changed before arready in test %s", test_name);
        end

    a_drop: assert property (@(posedge clk) disable iff (rst)
        req_valid && arready |=> !req_valid)
        else begin
            err_drop = err_drop + 1;
            $display("Request still valid after arready in test %s", test_name);
        end

    a_extra: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> req_idx != 2'd3)
        else begin
            err_extra = err_extra + 1;
            $display("Request issued after B in test %s", test_name);
        end

    a_count: assert property (@(posedge clk) disable iff (rst)
        done |-> req_idx == 2'd3)
        else begin
            err_count = err_count + 1;
            $display("FAILED %s: expected 3 requests, actual %0d", test_name, $sampled(req_idx));
        end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> since_b == exp_lat)
        else begin
            err_lat = err_lat + 1;
            $display("FAILED %s: expected latency %0d, actual %0d", test_name,
                     $sampled(exp_lat), $sampled(since_b));
        end

    a_cycles: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> int'(job_cycles) == cyc - acc_cyc - 1)
        else begin
            err_cycles = err_cycles + 1;
            $display("FAILED %s: expected job_cycles %0d, actual %0d", test_name,
                     $sampled(cyc) - $sampled(acc_cyc) - 1, $sampled(job_cycles));
        end

    a_flag: assert property (@(posedge clk) disable iff (rst)
        done || !cur_short |-> xfer_error == cur_short)
        else begin
            err_flag = err_flag + 1;
            $display("FAILED %s: expected xfer_error %b, actual %b", test_name,
                     $sampled(cur_short), $sampled(xfer_error));
        end

    a_clear: assert property (@(posedge clk) disable iff (rst)
        start && !busy |=> busy && !done && !xfer_error)
        else begin
            err_clear = err_clear + 1;
            $display("Accepted start did not clear done and xfer_error in test %s", test_name);
        end

    a_reset: assert property (@(posedge clk)
        rst |=> !req_valid && !busy && !done && !xfer_error)
        else begin
            err_reset = err_reset + 1;
            $display("Outputs not low after reset in test %s", test_name);
        end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic int total_errors();
        return err_desc + err_hold + err_drop + err_extra + err_count + err_lat
             + err_cycles + err_flag + err_clear + err_reset + err_timeout;
    endfunction

    task automatic apply_reset();
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic serve_burst(input logic cut);
        int waited;
        int delay;
        int beats;
        waited = 0;
        @(posedge clk);
        while (!req_valid && waited < 20) begin
            @(posedge clk);
            waited = waited + 1;
        end
        if (!req_valid) begin
            err_timeout = err_timeout + 1;
            $display("No request from the DUT in test %s", test_name);
        end else begin
            take_bits(3, delay);
            beats = int'(req_burst_num) + (cut ? 0 : 1);    // One beat short on request
            repeat (delay) @(posedge clk);
            arready <= 1'b1;
            @(posedge clk);
            arready <= 1'b0;
            repeat (beats) begin
                beat_valid <= 1'b1;
                @(posedge clk);
            end
            beat_valid  <= 1'b0;
            xfer_finish <= 1'b1;
            @(posedge clk);
            xfer_finish <= 1'b0;
        end
    endtask

    // Start with a different job while the DUT is busy
    task automatic poke_start(input shape_t s, input dtype_t d, input logic m);
        start         <= 1'b1;
        compute_shape <= (s == M8K16N32) ? M32K16N8 : M8K16N32;
        data_type     <= dtype_t'(~d);
        mixed         <= ~m;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // One cycle of start with the job fields
    task automatic start_job(input shape_t s, input dtype_t d, input logic m,
                             input logic short_job);
        next_shape    = s;
        next_dtype    = d;
        next_mixed    = m;
        next_short    = short_job;
        start         <= 1'b1;
        compute_shape <= s;
        data_type     <= d;
        mixed         <= m;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic run_job(input shape_t s, input dtype_t d, input logic m,
                           input int cut_idx, input logic poke);
        int waited;
        start_job(s, d, m, cut_idx >= 0);
        if (poke) begin
            poke_start(s, d, m);
        end
        for (int i = 0; i < 3; i++) begin
            serve_burst(i == cut_idx);
        end
        if (poke) begin
            poke_start(s, d, m);                            // During compute
        end
        waited = 0;
        while (!done && waited < LAT_INT4 + 10) begin
            @(posedge clk);
            waited = waited + 1;
        end
        if (!done) begin
            err_timeout = err_timeout + 1;
            $display("done never rose in test %s", test_name);
        end
        jobs = jobs + 1;
    endtask

    task automatic finish_test(input int err_base, input int job_base);
        int errs;
        errs = total_errors() - err_base;
        tests_run = tests_run + 1;
        if (errs != 0) begin
            tests_failed = tests_failed + 1;
        end
        $display("%-18s jobs %0d errors %0d %s", test_name, jobs - job_base, errs,
                 (errs == 0) ? "passed" : "failed");
    endtask

    initial begin
        int err_base;
        int job_base;
        int pick_s;
        int pick_d;
        int pick_m;
        rst           = 1'b1;
        start         = 1'b0;
        mixed         = 1'b0;
        compute_shape = M32K16N8;
        data_type     = FP32;
        arready       = 1'b0;
        xfer_finish   = 1'b0;
        beat_valid    = 1'b0;
        lfsr_state    = 16'd9274;
        test_name     = "reset";
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        finish_test(0, 0);

        test_name = "descriptor_table";
        err_base  = total_errors();
        job_base  = jobs;
        for (int s = 0; s < 3; s++) begin
            for (int d = 0; d < 4; d++) begin
                for (int m = 0; m < 2; m++) begin
                    run_job(shape_t'(s), dtype_t'(d), m[0], -1, 1'b0);
                end
            end
        end
        finish_test(err_base, job_base);

        test_name = "random_jobs";
        err_base  = total_errors();
        job_base  = jobs;
        repeat (8) begin
            take_bits(2, pick_s);
            take_bits(2, pick_d);
            take_bits(1, pick_m);
            run_job(shape_t'(pick_s % 3), dtype_t'(pick_d), pick_m[0], -1, 1'b0);
        end
        finish_test(err_base, job_base);

        test_name = "short_burst";
        err_base  = total_errors();
        job_base  = jobs;
        run_job(M16K16N16, INT8, 1'b0, 0, 1'b0);            // C one beat short
        run_job(M8K16N32, INT4, 1'b0, 2, 1'b0);             // B one beat short
        run_job(M32K16N8, FP16, 1'b1, -1, 1'b0);
        finish_test(err_base, job_base);

        test_name = "start_while_busy";
        err_base  = total_errors();
        job_base  = jobs;
        run_job(M16K16N16, FP32, 1'b0, -1, 1'b1);
        finish_test(err_base, job_base);

        test_name = "reset_mid_run";
        err_base  = total_errors();
        job_base  = jobs;
        run_job(M32K16N8, INT8, 1'b0, 1, 1'b0);             // Leaves done and xfer_error set
        apply_reset();
        start_job(M8K16N32, FP16, 1'b1, 1'b0);
        repeat (4) @(posedge clk);                          // C request left pending
        apply_reset();
        finish_test(err_base, job_base);

        repeat (5) @(posedge clk);
        $display("Tests run %0d, tests failed %0d, check failures %0d",
                 tests_run, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tensor_sched.f ====
source/tc_cfg_pkg.sv
source/tc_xfer_pkg.sv
source/job_decode.sv
source/load_sequencer.sv
source/compute_timer.sv
source/job_status.sv
source/tensor_sched.sv
tb/tb_tensor_sched.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the tensor_sched testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_tensor_sched \
    -f tensor_sched.f -o sim_tensor_sched
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tensor_sched > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see $LOG"
exit 1
